// File: src/bpu_config.svh
`ifndef BPU_CONFIG_SVH
`define BPU_CONFIG_SVH

// operand, pc and target width, tied to the 32-bit target slots
`define BPU_XLEN 32

// set index bits, 9 gives 512 sets
`define BPU_INDEX_WIDTH 9

// counters come out of reset weakly not taken
`define BPU_CNT_RESET 2'b01

// pc bit positions
`define BPU_SLOT_LSB 2   // pc[3:2] picks one of four slots
`define BPU_INDEX_LSB 4  // set index starts above the slot bits

`endif

// File: src/bpu_pkg.sv
`include "bpu_config.svh"

package bpu_pkg;

    typedef enum logic [3:0] {
        op_jal,
        op_jalr,
        op_beq,
        op_bne,
        op_blt,
        op_bge,
        op_bltu,
        op_bgeu,
        op_none
    } branch_op_e;

    // order matches the outcome counters
    typedef enum logic [2:0] {
        out_taken_right,
        out_taken_target_wrong,
        out_taken_predicted_not,
        out_not_taken_predicted_taken,
        out_not_taken_right
    } outcome_e;

    typedef struct packed {
        logic                 valid;
        branch_op_e           op;
        logic [`BPU_XLEN-1:0] pc;
        logic [`BPU_XLEN-1:0] src1;
        logic [`BPU_XLEN-1:0] src2;
        logic [`BPU_XLEN-1:0] imm;
    } branch_req_t;

    typedef struct packed {
        logic                 taken;
        logic [`BPU_XLEN-1:0] target;
    } prediction_t;

    typedef struct packed {
        logic                        enable;
        logic [`BPU_INDEX_WIDTH-1:0] index;
        logic [1:0]                  slot;   // pc[3:2]
        logic                        inc;
        logic                        dec;
    } bht_update_t;

    // bit 128 is the set valid bit, then four targets, slot 3 on top
    typedef struct packed {
        logic                        enable;
        logic [`BPU_INDEX_WIDTH-1:0] index;
        logic [`BPU_XLEN*4:0]        mask;
        logic [`BPU_XLEN*4:0]        data;
    } btb_update_t;

    typedef struct packed {
        logic                 valid;
        logic [`BPU_XLEN-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic [31:0] taken_right;
        logic [31:0] taken_target_wrong;
        logic [31:0] taken_predicted_not;
        logic [31:0] not_taken_predicted_taken;
        logic [31:0] not_taken_right;
    } outcome_counts_t;

endpackage

// File: src/bht.sv
`include "bpu_config.svh"

module bht (
    input  logic                        clock,
    input  logic                        reset_n,
    input  logic [`BPU_INDEX_WIDTH-1:0] read_index,
    input  logic [1:0]                  read_slot,
    input  bpu_pkg::bht_update_t        upd,
    output logic [1:0]                  counter
);

    localparam int num_sets = 2 ** `BPU_INDEX_WIDTH;

    // four 2-bit counters per set
    logic [3:0][1:0] counters_q [num_sets];
    logic [1:0]      cur_count;

    assign counter   = counters_q[read_index][read_slot];
    assign cur_count = counters_q[upd.index][upd.slot];

    // saturating at 00 and 11
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < num_sets; i++) begin
                counters_q[i] <= {4{`BPU_CNT_RESET}};
            end
        end else if (upd.enable) begin
            if (upd.inc && (cur_count != 2'b11)) begin
                counters_q[upd.index][upd.slot] <= cur_count + 2'd1;
            end else if (upd.dec && (cur_count != 2'b00)) begin
                counters_q[upd.index][upd.slot] <= cur_count - 2'd1;
            end
        end
    end

endmodule

// File: src/btb.sv
`include "bpu_config.svh"

module btb (
    input  logic                        clock,
    input  logic                        reset_n,
    input  logic [`BPU_INDEX_WIDTH-1:0] read_index,
    output logic                        set_valid,
    output logic [`BPU_XLEN*4-1:0]      set_targets,
    input  bpu_pkg::btb_update_t        upd
);

    localparam int num_sets  = 2 ** `BPU_INDEX_WIDTH;
    localparam int valid_bit = `BPU_XLEN * 4;   // top bit of mask and data

    logic                   valid_q   [num_sets];
    logic [`BPU_XLEN*4-1:0] targets_q [num_sets];
    logic [`BPU_XLEN*4-1:0] target_mask;

    assign set_valid   = valid_q[read_index];
    assign set_targets = targets_q[read_index];

    assign target_mask = upd.mask[`BPU_XLEN*4-1:0];

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < num_sets; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (upd.enable && upd.mask[valid_bit]) begin
            valid_q[upd.index] <= upd.data[valid_bit];
        end
    end

    // masked write keeps the other slots of the set
    always_ff @(posedge clock) begin
        if (upd.enable) begin
            targets_q[upd.index] <= (targets_q[upd.index] & ~target_mask)
                                  | (upd.data[`BPU_XLEN*4-1:0] & target_mask);
        end
    end

endmodule

// File: src/branch_predictor.sv
`include "bpu_config.svh"

module branch_predictor (
    input  logic                 clock,
    input  logic                 reset_n,
    input  logic [`BPU_XLEN-1:0] pc,
    output bpu_pkg::prediction_t pred,
    input  bpu_pkg::bht_update_t bht_upd,
    input  bpu_pkg::btb_update_t btb_upd
);

    logic [`BPU_INDEX_WIDTH-1:0] read_index;
    logic [1:0]                  read_slot;
    logic [1:0]                  counter;
    logic                        set_valid;
    logic [`BPU_XLEN*4-1:0]      set_targets;

    assign read_index = pc[`BPU_INDEX_LSB +: `BPU_INDEX_WIDTH];
    assign read_slot  = pc[`BPU_SLOT_LSB +: 2];

    bht u_bht (
        .clock      (clock),
        .reset_n    (reset_n),
        .read_index (read_index),
        .read_slot  (read_slot),
        .upd        (bht_upd),
        .counter    (counter)
    );

    btb u_btb (
        .clock       (clock),
        .reset_n     (reset_n),
        .read_index  (read_index),
        .set_valid   (set_valid),
        .set_targets (set_targets),
        .upd         (btb_upd)
    );

    // direction from counter msb, only trusted once the set has a target
    assign pred.taken  = counter[1] & set_valid;
    assign pred.target = pred.taken ? set_targets[read_slot * `BPU_XLEN +: `BPU_XLEN]
                                    : '0;

endmodule

// File: src/bju.sv
`include "bpu_config.svh"

module bju (
    input  logic                     clock,
    input  logic                     reset_n,
    input  bpu_pkg::branch_req_t     req,
    input  bpu_pkg::prediction_t     pred,
    output logic [`BPU_XLEN-1:0]     dest,
    output bpu_pkg::redirect_t       redirect,
    output bpu_pkg::bht_update_t     bht_upd,
    output bpu_pkg::btb_update_t     btb_upd,
    output bpu_pkg::outcome_counts_t counts
);

    logic                        is_branch;
    logic                        equal;
    logic                        less_signed;
    logic                        less_unsigned;
    logic                        taken;
    logic [`BPU_XLEN-1:0]        taken_target;
    logic [`BPU_XLEN-1:0]        fall_through;
    logic [`BPU_INDEX_WIDTH-1:0] set_index;
    logic [1:0]                  slot;
    logic [`BPU_XLEN*4:0]        slot_mask;
    logic [`BPU_XLEN*4:0]        slot_data;
    bpu_pkg::outcome_e           outcome;

    assign is_branch = req.valid && (req.op != bpu_pkg::op_none);

    assign equal         = (req.src1 == req.src2);
    assign less_signed   = $signed(req.src1) < $signed(req.src2);
    assign less_unsigned = req.src1 < req.src2;

    // resolved direction
    always_comb begin
        case (req.op)
            bpu_pkg::op_jal,
            bpu_pkg::op_jalr: taken = 1'b1;
            bpu_pkg::op_beq:  taken = equal;
            bpu_pkg::op_bne:  taken = !equal;
            bpu_pkg::op_blt:  taken = less_signed;
            bpu_pkg::op_bge:  taken = !less_signed;
            bpu_pkg::op_bltu: taken = less_unsigned;
            bpu_pkg::op_bgeu: taken = !less_unsigned;
            default:          taken = 1'b0;
        endcase
    end

    assign taken_target = (req.op == bpu_pkg::op_jalr) ? req.src1 + req.imm
                                                       : req.pc + req.imm;
    assign fall_through = req.pc + `BPU_XLEN'd4;
    assign dest         = fall_through;   // link value

    assign set_index = req.pc[`BPU_INDEX_LSB +: `BPU_INDEX_WIDTH];
    assign slot      = req.pc[`BPU_SLOT_LSB +: 2];

    // valid bit always written, target lands in its own slot
    assign slot_mask = {1'b1, {(`BPU_XLEN*4){1'b0}}}
                     | ({{(`BPU_XLEN*3+1){1'b0}}, {`BPU_XLEN{1'b1}}} << (slot * `BPU_XLEN));
    assign slot_data = {1'b1, {(`BPU_XLEN*4){1'b0}}}
                     | ({{(`BPU_XLEN*3+1){1'b0}}, taken_target} << (slot * `BPU_XLEN));

    // compare against the prediction
    always_comb begin
        if (taken && pred.taken && (taken_target == pred.target)) begin
            outcome = bpu_pkg::out_taken_right;
        end else if (taken && pred.taken) begin
            outcome = bpu_pkg::out_taken_target_wrong;
        end else if (taken) begin
            outcome = bpu_pkg::out_taken_predicted_not;
        end else if (pred.taken) begin
            outcome = bpu_pkg::out_not_taken_predicted_taken;
        end else begin
            outcome = bpu_pkg::out_not_taken_right;
        end
    end

    always_comb begin
        redirect = '0;
        bht_upd  = '0;
        btb_upd  = '0;
        if (is_branch) begin
            bht_upd.enable = 1'b1;
            bht_upd.index  = set_index;
            bht_upd.slot   = slot;
            case (outcome)
                bpu_pkg::out_taken_right: begin
                    bht_upd.inc = 1'b1;
                end
                bpu_pkg::out_taken_target_wrong,
                bpu_pkg::out_taken_predicted_not: begin
                    bht_upd.inc     = 1'b1;
                    redirect.valid  = 1'b1;
                    redirect.target = taken_target;
                    btb_upd.enable  = 1'b1;   // train the target
                    btb_upd.index   = set_index;
                    btb_upd.mask    = slot_mask;
                    btb_upd.data    = slot_data;
                end
                bpu_pkg::out_not_taken_predicted_taken: begin
                    bht_upd.dec     = 1'b1;
                    redirect.valid  = 1'b1;
                    redirect.target = fall_through;   // back to the next instruction
                end
                default: begin
                    bht_upd.dec = 1'b1;   // fell through as predicted
                end
            endcase
        end
    end

    // outcome counters
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            counts <= '0;
        end else if (is_branch) begin
            case (outcome)
                bpu_pkg::out_taken_right:
                    counts.taken_right <= counts.taken_right + 32'd1;
                bpu_pkg::out_taken_target_wrong:
                    counts.taken_target_wrong <= counts.taken_target_wrong + 32'd1;
                bpu_pkg::out_taken_predicted_not:
                    counts.taken_predicted_not <= counts.taken_predicted_not + 32'd1;
                bpu_pkg::out_not_taken_predicted_taken:
                    counts.not_taken_predicted_taken <=
                        counts.not_taken_predicted_taken + 32'd1;
                bpu_pkg::out_not_taken_right:
                    counts.not_taken_right <= counts.not_taken_right + 32'd1;
                default: begin
                end
            endcase
        end
    end

endmodule

// File: src/branch_unit_top.sv
`include "bpu_config.svh"

module branch_unit_top (
    input  logic                     clock,
    input  logic                     reset_n,
    input  bpu_pkg::branch_req_t     req,
    output logic [`BPU_XLEN-1:0]     dest,
    output bpu_pkg::redirect_t       redirect,
    output bpu_pkg::outcome_counts_t counts
);

    bpu_pkg::prediction_t pred;
    bpu_pkg::bht_update_t bht_upd;
    bpu_pkg::btb_update_t btb_upd;

    // prediction for the branch in this cycle
    branch_predictor u_branch_predictor (
        .clock   (clock),
        .reset_n (reset_n),
        .pc      (req.pc),
        .pred    (pred),
        .bht_upd (bht_upd),
        .btb_upd (btb_upd)
    );

    bju u_bju (
        .clock    (clock),
        .reset_n  (reset_n),
        .req      (req),
        .pred     (pred),
        .dest     (dest),
        .redirect (redirect),
        .bht_upd  (bht_upd),
        .btb_upd  (btb_upd),
        .counts   (counts)
    );

endmodule

// File: dv/branch_checker.sv
`include "bpu_config.svh"

module branch_checker (
    input  logic                     clock,
    input  logic                     reset_n,
    input  bpu_pkg::branch_req_t     req,
    input  logic [`BPU_XLEN-1:0]     dest,
    input  bpu_pkg::redirect_t       redirect,
    input  bpu_pkg::outcome_counts_t counts,
    input  logic [`BPU_XLEN-1:0]     exp_dest,
    input  bpu_pkg::redirect_t       exp_redirect,
    input  bpu_pkg::outcome_e        exp_outcome,
    input  bpu_pkg::outcome_counts_t exp_counts,
    input  int                       group_id,
    input  logic                     final_check,
    output logic                     checker_done,
    output int                       check_count,
    output int                       error_count
);
    timeunit 1ns;
    timeprecision 100ps;

    int                       tally [5];   // expected outcomes so far
    bpu_pkg::outcome_counts_t tally_counts;
    int                       cur_group;
    int                       group_errors;

    assign tally_counts = {tally[0], tally[1], tally[2], tally[3], tally[4]};

    initial begin
        checker_done = 1'b0;
        check_count  = 0;
        error_count  = 0;
        cur_group    = 0;
        group_errors = 0;
        for (int i = 0; i < 5; i++) begin
            tally[i] = 0;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            $display("MISMATCH %s expected %h actual %h at %0t", name, expected, actual, $time);
            error_count++;
            group_errors++;
        end
    endtask

    task automatic check_counts(input bpu_pkg::outcome_counts_t expected);
        check_value("counts.taken_right", expected.taken_right, counts.taken_right);
        check_value("counts.taken_target_wrong", expected.taken_target_wrong,
                    counts.taken_target_wrong);
        check_value("counts.taken_predicted_not", expected.taken_predicted_not,
                    counts.taken_predicted_not);
        check_value("counts.not_taken_predicted_taken", expected.not_taken_predicted_taken,
                    counts.not_taken_predicted_taken);
        check_value("counts.not_taken_right", expected.not_taken_right, counts.not_taken_right);
    endtask

    task automatic report_group();
        if (cur_group > 0) begin
            $display("test group %0d finished with %0d errors", cur_group, group_errors);
        end
    endtask

    always @(posedge clock) begin
        #3.5;   // just before the next edge
        if (reset_n && req.valid) begin
            if (group_id != cur_group) begin
                report_group();
                cur_group    = group_id;
                group_errors = 0;
            end
            check_counts(tally_counts);   // earlier branches have landed
            check_value("dest", exp_dest, dest);
            check_value("redirect.valid", exp_redirect.valid, redirect.valid);
            check_value("redirect.target", exp_redirect.target, redirect.target);
            tally[int'(exp_outcome)]++;
        end else if (reset_n) begin
            check_value("redirect.valid", 32'd0, redirect.valid);   // idle cycle
        end
        if (reset_n && final_check && !checker_done) begin
            report_group();
            check_counts(exp_counts);
            if (tally_counts != exp_counts) begin
                $display("closing counts line differs from the tally of expected outcomes");
                error_count++;
            end
            checker_done = 1'b1;
        end
    end

endmodule

// File: dv/tb_branch_unit.sv
`include "bpu_config.svh"

module tb_branch_unit;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int reset_cycles = 5;
    localparam int max_wait     = 32;    // longest idle run per wait
    localparam int max_items    = 600;

    logic                     clock;
    logic                     reset_n;
    bpu_pkg::branch_req_t     req;
    logic [`BPU_XLEN-1:0]     dest;
    bpu_pkg::redirect_t       redirect;
    bpu_pkg::outcome_counts_t counts;
    logic [`BPU_XLEN-1:0]     exp_dest;
    bpu_pkg::redirect_t       exp_redirect;
    bpu_pkg::outcome_e        exp_outcome;
    bpu_pkg::outcome_counts_t exp_counts;
    int                       group_id;
    logic                     final_check;
    logic                     checker_done;
    int                       check_count;
    int                       error_count;
    int                       seed;
    int                       fd;
    int                       items;
    int                       waited;
    int                       file_errors;
    logic                     at_end;
    logic                     counts_seen;
    logic                     timed_out;
    logic [63:0]              kind;        // first token of an item
    logic [8*160-1:0]         line_buf;

    branch_unit_top uut (.*);

    branch_checker u_checker (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task automatic step();
        @(posedge clock);
        #1;
    endtask

    task automatic wait_cycles(input int n);
        int i;
        i = 0;
        while (i < n && i < max_wait) begin
            step();
            i++;
        end
        if (i < n) begin
            $display("idle run of %0d cycles stopped at the %0d cycle limit", n, max_wait);
            timed_out = 1'b1;
        end
    endtask

    task automatic read_branch();
        logic [63:0] op_tok;
        logic [63:0] out_tok;
        logic [31:0] pc;
        logic [31:0] src1;
        logic [31:0] src2;
        logic [31:0] imm;
        logic [31:0] e_dest;
        logic [31:0] e_rv;
        logic [31:0] e_rt;
        int          gap;
        int          n;
        logic        ok;
        n = $fscanf(fd, "%s %h %h %h %h %d %h %h %h %s",
                    op_tok, pc, src1, src2, imm, gap, e_dest, e_rv, e_rt, out_tok);
        ok = (n == 10);
        case (op_tok)
            "jal":   req.op = bpu_pkg::op_jal;
            "jalr":  req.op = bpu_pkg::op_jalr;
            "beq":   req.op = bpu_pkg::op_beq;
            "bne":   req.op = bpu_pkg::op_bne;
            "blt":   req.op = bpu_pkg::op_blt;
            "bge":   req.op = bpu_pkg::op_bge;
            "bltu":  req.op = bpu_pkg::op_bltu;
            "bgeu":  req.op = bpu_pkg::op_bgeu;
            default: ok = 1'b0;
        endcase
        case (out_tok)
            "tr":    exp_outcome = bpu_pkg::out_taken_right;
            "tw":    exp_outcome = bpu_pkg::out_taken_target_wrong;
            "tp":    exp_outcome = bpu_pkg::out_taken_predicted_not;
            "np":    exp_outcome = bpu_pkg::out_not_taken_predicted_taken;
            "nr":    exp_outcome = bpu_pkg::out_not_taken_right;
            default: ok = 1'b0;
        endcase
        if (!ok) begin
            $display("stimulus item %0d is not a well formed branch line", items);
            file_errors++;
            at_end = 1'b1;
        end else begin
            req.valid           = 1'b1;
            req.pc              = pc;
            req.src1            = src1;
            req.src2            = src2;
            req.imm             = imm;
            exp_dest            = e_dest;
            exp_redirect.valid  = e_rv[0];
            exp_redirect.target = e_rt;
            step();
            req.valid = 1'b0;
            wait_cycles(gap + $unsigned($random(seed)) % 3);   // extra random idle cycles
        end
    endtask

    task automatic handle_item();
        int          n;
        int          gid;
        logic [31:0] c0;
        logic [31:0] c1;
        logic [31:0] c2;
        logic [31:0] c3;
        logic [31:0] c4;
        if (kind == "#") begin
            n = $fgets(line_buf, fd);   // rest of a comment line
        end else if (kind == "group") begin
            n = $fscanf(fd, "%d", gid);
            group_id = gid;
        end else if (kind == "br") begin
            read_branch();
        end else if (kind == "counts") begin
            n = $fscanf(fd, "%h %h %h %h %h", c0, c1, c2, c3, c4);
            exp_counts  = {c0, c1, c2, c3, c4};
            counts_seen = (n == 5);
        end else begin
            $display("stimulus file holds an item that is not a branch, group or counts line");
            file_errors++;
            at_end = 1'b1;
        end
    endtask

    initial begin
        req          = '0;
        req.op       = bpu_pkg::op_none;
        exp_dest     = '0;
        exp_redirect = '0;
        exp_outcome  = bpu_pkg::out_not_taken_right;
        exp_counts   = '0;
        group_id     = 0;
        final_check  = 1'b0;
        seed         = 32'h20cd6e20;
        items        = 0;
        file_errors  = 0;
        at_end       = 1'b0;
        counts_seen  = 1'b0;
        timed_out    = 1'b0;
        reset_n      = 1'b0;
        for (int i = 0; i < reset_cycles; i++) begin
            @(posedge clock);
        end
        #1;
        reset_n = 1'b1;
        step();
        fd = $fopen("dv/branch_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open dv/branch_stimulus.txt for reading");
            file_errors++;
        end else begin
            while (!at_end && !counts_seen && items < max_items) begin
                items++;
                kind = '0;
                if ($fscanf(fd, "%s", kind) != 1) begin
                    at_end = 1'b1;
                end else begin
                    handle_item();
                end
            end
            $fclose(fd);
            if (!counts_seen) begin
                $display("stimulus file has no readable closing counts line");
                file_errors++;
            end
        end
        final_check = 1'b1;
        step();
        final_check = 1'b0;
        waited = 0;
        while (!checker_done && waited < max_wait) begin
            step();
            waited++;
        end
        if (!checker_done) begin
            $display("checker did not finish within %0d cycles", max_wait);
            timed_out = 1'b1;
        end
        $display("%0d checks, %0d mismatches, %0d file errors", check_count, error_count,
                 file_errors);
        if (!timed_out && error_count == 0 && file_errors == 0 && check_count > 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: dv/branch_stimulus.txt
# br op pc src1 src2 imm gap, then expected dest redirect_valid redirect_target outcome
# outcome tr taken right, tw target wrong, tp taken predicted not, np/nr not taken
# resolution of all eight opcodes on a cold table
group 1
br jal  00001000 00000000 00000000 00000100 0 00001004 1 00001100 tp
br jalr 00001010 00002000 00000000 00000024 1 00001014 1 00002024 tp
br beq  00001020 00000005 00000005 00000040 0 00001024 1 00001060 tp
br bne  00001030 00000005 00000005 00000040 0 00001034 0 00000000 nr
br blt  00001040 ffffffff 00000001 fffffff0 2 00001044 1 00001030 tp
br bltu 00001050 ffffffff 00000001 00000010 0 00001054 0 00000000 nr
br bge  00001060 80000000 00000001 00000008 0 00001064 0 00000000 nr
br bgeu 00001070 80000000 00000001 00000008 1 00001074 1 00001078 tp
# learning, one taken branch repeated
group 2
br beq  00000200 00000007 00000007 00000100 0 00000204 1 00000300 tp
br beq  00000200 00000007 00000007 00000100 0 00000204 0 00000000 tr
br beq  00000200 00000007 00000007 00000100 1 00000204 0 00000000 tr
# target change of a trained jalr
group 3
br jalr 00000300 00004000 00000000 00000000 0 00000304 1 00004000 tp
br jalr 00000300 00004000 00000000 00000000 0 00000304 0 00000000 tr
br jalr 00000300 00005000 00000000 00000000 0 00000304 1 00005000 tw
br jalr 00000300 00005000 00000000 00000000 2 00000304 0 00000000 tr
# trained branch falls through and decays toward not taken
group 4
br bne  00000400 00000001 00000002 00000080 0 00000404 1 00000480 tp
br bne  00000400 00000001 00000002 00000080 0 00000404 0 00000000 tr
br bne  00000400 00000002 00000002 00000080 0 00000404 1 00000404 np
br bne  00000400 00000002 00000002 00000080 0 00000404 1 00000404 np
br bne  00000400 00000002 00000002 00000080 1 00000404 0 00000000 nr
# slot isolation within one set
group 5
br beq  00000500 00000003 00000003 00000020 0 00000504 1 00000520 tp
br beq  00000504 00000003 00000003 00000040 0 00000508 1 00000544 tp
br beq  00000500 00000003 00000003 00000020 0 00000504 0 00000000 tr
br beq  00000504 00000003 00000003 00000040 0 00000508 0 00000000 tr
br bne  00000508 00000003 00000003 00000060 0 0000050c 0 00000000 nr
br beq  00000508 00000003 00000003 00000060 0 0000050c 1 00000568 tp
br beq  00000500 00000003 00000003 00000020 0 00000504 0 00000000 tr
br bne  00000504 00000003 00000003 00000040 0 00000508 1 00000508 np
# closing line, counts in outcome order tr tw tp np nr
counts 00000008 00000001 0000000b 00000003 00000005

// File: build.f
+incdir+src
src/bpu_pkg.sv
src/bht.sv
src/btb.sv
src/branch_predictor.sv
src/bju.sv
src/branch_unit_top.sv
dv/branch_checker.sv
dv/tb_branch_unit.sv
